// ==== design/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  wire       clk,
  input  wire       rst,
  input  wire uop_t uop,
  output wb_t       result,
  output cancel_t   cancel_rd
);

  function automatic logic cond_true(cond_e cond, flags_t f);
    case (cond)
      cond_z:  return f.z;
      cond_nz: return !f.z;
      cond_c:  return f.c;
      cond_nc: return !f.c;
      cond_n:  return f.n;
      cond_nn: return !f.n;
      cond_v:  return f.v;
      cond_nv: return !f.v;
      cond_hi: return f.c && !f.z;
      cond_ls: return !f.c || f.z;
      cond_ge: return f.n == f.v;
      cond_lt: return f.n != f.v;
      cond_al: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  logic          take;
  logic          sub;
  word_t         b_in;
  logic [word_w:0] sum;
  word_t         res;
  flags_t        fl;
  wb_t           res_q;
  logic          res_v_q;
  logic          cancel_v_q;

  assign take = cond_true(uop.cond, uop.tflags);
  assign sub  = uop.opcode == op_sub;
  // subtract as a + ~b + 1, so c is not borrow
  assign b_in = sub ? ~uop.b : uop.b;
  assign sum  = {1'b0, uop.a} + {1'b0, b_in} + {{word_w{1'b0}}, sub};

  always_comb begin
    fl = '0;
    case (uop.opcode)
      op_and: res = uop.a & uop.b;
      op_xor: res = uop.a ^ uop.b;
      op_or:  res = uop.a | uop.b;
      op_shl: res = uop.a << uop.b[5:0];
      op_shr: res = uop.a >> uop.b[5:0];
      op_sar: res = $signed(uop.a) >>> uop.b[5:0];
      default: begin
        res  = sum[word_w-1:0];
        fl.c = sum[word_w];
        fl.v = (uop.a[word_w-1] == b_in[word_w-1]) && (res[word_w-1] != uop.a[word_w-1]);
      end
    endcase
    fl.n = res[word_w-1];
    fl.z = res == '0;
  end

  always_ff @(posedge clk) begin
    res_q <= '{valid: 1'b1, rd: uop.rd, data: res, flags: fl};
    if (rst) begin
      res_v_q    <= 1'b0;
      cancel_v_q <= 1'b0;
    end else begin
      res_v_q    <= uop.valid && take;
      cancel_v_q <= uop.valid && !take;
    end
  end

  always_comb begin
    result          = res_q;
    result.valid    = res_v_q;
    cancel_rd.valid = cancel_v_q;
    cancel_rd.rd    = res_q.rd;
  end

endmodule

`default_nettype wire

// ==== design/exec_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_cluster
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        issue_valid,
  input  wire insn_u issue_insn,
  output logic       issue_ready,
  output wb_t        wb
);

  reg_idx_t rd_addr_a;
  reg_idx_t rd_addr_b;
  reg_idx_t rd_addr_f;
  word_t    rd_data_a;
  word_t    rd_data_b;
  flags_t   rd_flags;
  uop_t     alu_uop;
  uop_t     mul_uop;
  wb_t      alu_result;
  wb_t      mul_result;
  cancel_t  cancel_rd;
  logic     alu_hold_full;

  issue_ctrl u_issue (
    .clk           (clk),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .issue_insn    (issue_insn),
    .alu_hold_full (alu_hold_full),
    .wb_done       (wb),
    .cancel_rd     (cancel_rd),
    .issue_ready   (issue_ready),
    .rd_addr_a     (rd_addr_a),
    .rd_addr_b     (rd_addr_b),
    .rd_addr_f     (rd_addr_f),
    .rd_data_a     (rd_data_a),
    .rd_data_b     (rd_data_b),
    .rd_flags      (rd_flags),
    .alu_uop       (alu_uop),
    .mul_uop       (mul_uop)
  );

  reg_file u_regs (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_addr_f (rd_addr_f),
    .wr        (wb),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .rd_flags  (rd_flags)
  );

  alu_unit u_alu (
    .clk       (clk),
    .rst       (rst),
    .uop       (alu_uop),
    .result    (alu_result),
    .cancel_rd (cancel_rd)
  );

  mul_unit u_mul (
    .clk    (clk),
    .rst    (rst),
    .uop    (mul_uop),
    .result (mul_result)
  );

  writeback_arbiter u_arb (
    .clk           (clk),
    .rst           (rst),
    .alu_result    (alu_result),
    .mul_result    (mul_result),
    .wr            (wb),
    .alu_hold_full (alu_hold_full)
  );

endmodule

`default_nettype wire

// ==== design/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  localparam int word_w     = 64;
  localparam int num_regs   = 16;
  localparam int mul_stages = 3;

  typedef logic [word_w-1:0] word_t;
  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

  typedef struct packed {
    logic c;
    logic v;
    logic n;
    logic z;
  } flags_t;

  typedef struct packed {
    logic              valid;
    isa_pkg::opcode_e  opcode;
    isa_pkg::cond_e    cond;
    reg_idx_t          rd;
    word_t             a;
    word_t             b;
    flags_t            tflags;
  } uop_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
    flags_t   flags;
  } wb_t;

  // condition-false ALU op, releases rd without a write
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
  } cancel_t;

endpackage

`default_nettype wire

// ==== design/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int insn_w = 40;

  typedef enum logic [4:0] {
    op_add    = 5'd0,
    op_sub    = 5'd1,
    op_and    = 5'd2,
    op_xor    = 5'd3,
    op_or     = 5'd4,
    op_shl    = 5'd5,
    op_shr    = 5'd6,
    op_sar    = 5'd7,
    op_mul_lo = 5'd8,
    op_mul_hu = 5'd9,
    op_mul_hs = 5'd10
  } opcode_e;

  // codes 14 and 15 also never pass
  typedef enum logic [3:0] {
    cond_z     = 4'd0,
    cond_nz    = 4'd1,
    cond_c     = 4'd2,
    cond_nc    = 4'd3,
    cond_n     = 4'd4,
    cond_nn    = 4'd5,
    cond_v     = 4'd6,
    cond_nv    = 4'd7,
    cond_hi    = 4'd8,
    cond_ls    = 4'd9,
    cond_ge    = 4'd10,
    cond_lt    = 4'd11,
    cond_al    = 4'd12,
    cond_never = 4'd13
  } cond_e;

  localparam opcode_e mul_op_first = op_mul_lo;
  localparam opcode_e mul_op_last  = op_mul_hs;

  typedef struct packed {
    logic        fmt;
    opcode_e     opcode;
    cond_e       cond;
    logic [3:0]  rd;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  rf;
    logic [13:0] unused;
  } reg_insn_t;

  // imm replaces rb, no condition field
  typedef struct packed {
    logic        fmt;
    opcode_e     opcode;
    logic [3:0]  rd;
    logic [3:0]  ra;
    logic [25:0] imm;
  } imm_insn_t;

  typedef union packed {
    reg_insn_t reg_fmt;
    imm_insn_t imm_fmt;
  } insn_u;

  // unknown opcodes above the mul range fall back to add in the ALU
  function automatic logic is_mul_op(opcode_e op);
    return (op >= mul_op_first) && (op <= mul_op_last);
  endfunction

endpackage

`default_nettype wire

// ==== design/issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire           issue_valid,
  input  wire insn_u    issue_insn,
  input  wire           alu_hold_full,
  input  wire wb_t      wb_done,
  input  wire cancel_t  cancel_rd,
  output logic          issue_ready,
  output reg_idx_t      rd_addr_a,
  output reg_idx_t      rd_addr_b,
  output reg_idx_t      rd_addr_f,
  input  wire word_t    rd_data_a,
  input  wire word_t    rd_data_b,
  input  wire flags_t   rd_flags,
  output uop_t          alu_uop,
  output uop_t          mul_uop
);

  logic [num_regs-1:0] pending_q;
  logic [num_regs-1:0] pending_next;
  logic [1:0]          mul_due_q;
  logic                alu_v_q;
  logic                mul_v_q;
  uop_t                uop_q;
  uop_t                dec_uop;
  reg_idx_t            dec_rd;
  logic                is_imm;
  logic                to_mul;
  logic                hazard;
  logic                mul_block;
  logic                accept;

  assign is_imm = issue_insn.reg_fmt.fmt;

  always_comb begin
    dec_uop.valid  = 1'b1;
    dec_uop.a      = rd_data_a;
    dec_uop.tflags = rd_flags;
    if (is_imm) begin
      dec_rd         = issue_insn.imm_fmt.rd;
      rd_addr_a      = issue_insn.imm_fmt.ra;
      rd_addr_b      = issue_insn.imm_fmt.ra;
      rd_addr_f      = issue_insn.imm_fmt.ra;
      dec_uop.opcode = issue_insn.imm_fmt.opcode;
      dec_uop.cond   = cond_al;
      dec_uop.b      = {{(word_w-26){issue_insn.imm_fmt.imm[25]}}, issue_insn.imm_fmt.imm};
    end else begin
      dec_rd         = issue_insn.reg_fmt.rd;
      rd_addr_a      = issue_insn.reg_fmt.ra;
      rd_addr_b      = issue_insn.reg_fmt.rb;
      rd_addr_f      = issue_insn.reg_fmt.rf;
      dec_uop.opcode = issue_insn.reg_fmt.opcode;
      dec_uop.cond   = issue_insn.reg_fmt.cond;
      dec_uop.b      = rd_data_b;
    end
    dec_uop.rd = dec_rd;
  end

  assign to_mul = is_mul_op(dec_uop.opcode);

  assign hazard = pending_q[dec_rd] | pending_q[rd_addr_a] |
                  (!is_imm & (pending_q[rd_addr_b] | pending_q[rd_addr_f]));

  // would land a third ALU result on two back-to-back mul results
  assign mul_block = !to_mul && alu_v_q && mul_due_q[0] && mul_due_q[1];

  assign issue_ready = !alu_hold_full && !hazard && !mul_block;
  assign accept      = issue_valid && issue_ready;

  always_comb begin
    pending_next = pending_q;
    if (wb_done.valid)
      pending_next[wb_done.rd] = 1'b0;
    if (cancel_rd.valid)
      pending_next[cancel_rd.rd] = 1'b0;
    if (accept)
      pending_next[dec_rd] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (accept)
      uop_q <= dec_uop;
    if (rst) begin
      pending_q <= '0;
      alu_v_q   <= 1'b0;
      mul_v_q   <= 1'b0;
      mul_due_q <= '0;
    end else begin
      pending_q <= pending_next;
      alu_v_q   <= accept && !to_mul;
      mul_v_q   <= accept && to_mul;
      // shadow of mul stages 1 and 2
      mul_due_q <= {mul_due_q[0], mul_v_q};
    end
  end

  always_comb begin
    alu_uop       = uop_q;
    alu_uop.valid = alu_v_q;
    mul_uop       = uop_q;
    mul_uop.valid = mul_v_q;
  end

  // nothing in flight still targets the rd of an accepted instruction
  a_rd_free: assert property (@(posedge clk) disable iff (rst)
    accept |-> !(wb_done.valid && wb_done.rd == dec_rd) &&
               !((alu_v_q || mul_v_q) && uop_q.rd == dec_rd));

  // every writeback must retire an instruction issued earlier
  a_wb_pending: assert property (@(posedge clk) disable iff (rst)
    wb_done.valid |-> pending_q[wb_done.rd]);

endmodule

`default_nettype wire

// ==== design/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  wire       clk,
  input  wire       rst,
  input  wire uop_t uop,
  output wb_t       result
);

  logic [mul_stages-1:0]   vld_q;
  opcode_e                 op1_q;
  opcode_e                 op2_q;
  reg_idx_t                rd1_q;
  reg_idx_t                rd2_q;
  reg_idx_t                rd3_q;
  word_t                   a1_q;
  word_t                   b1_q;
  logic [2*word_w-1:0]     prod2_q;
  word_t                   data3_q;
  flags_t                  flags3_q;
  logic signed [word_w:0]  a_ext;
  logic signed [word_w:0]  b_ext;
  logic signed [2*word_w+1:0] prod;
  word_t                   res;

  // one extra bit turns the unsigned forms into a signed multiply
  assign a_ext = {(op1_q == op_mul_hs) && a1_q[word_w-1], a1_q};
  assign b_ext = {(op1_q == op_mul_hs) && b1_q[word_w-1], b1_q};
  assign prod  = a_ext * b_ext;

  assign res = (op2_q == op_mul_lo) ? prod2_q[word_w-1:0] : prod2_q[2*word_w-1:word_w];

  always_ff @(posedge clk) begin
    if (rst)
      vld_q <= '0;
    else
      vld_q <= {vld_q[mul_stages-2:0], uop.valid};
    // stage 1 operands
    op1_q    <= uop.opcode;
    rd1_q    <= uop.rd;
    a1_q     <= uop.a;
    b1_q     <= uop.b;
    // stage 2 full product
    op2_q    <= op1_q;
    rd2_q    <= rd1_q;
    prod2_q  <= prod[2*word_w-1:0];
    // stage 3 select and flags
    rd3_q    <= rd2_q;
    data3_q  <= res;
    flags3_q <= '{c: 1'b0, v: 1'b0, n: res[word_w-1], z: res == '0};
  end

  always_comb begin
    result.valid = vld_q[mul_stages-1];
    result.rd    = rd3_q;
    result.data  = data3_q;
    result.flags = flags3_q;
  end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import exec_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire reg_idx_t rd_addr_a,
  input  wire reg_idx_t rd_addr_b,
  input  wire reg_idx_t rd_addr_f,
  input  wire wb_t      wr,
  output word_t         rd_data_a,
  output word_t         rd_data_b,
  output flags_t        rd_flags
);

  word_t  data_q  [num_regs];
  flags_t flags_q [num_regs];

  // data and flags always written as a pair
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        data_q[i]  <= '0;
        flags_q[i] <= '0;
      end
    end else if (wr.valid) begin
      data_q[wr.rd]  <= wr.data;
      flags_q[wr.rd] <= wr.flags;
    end
  end

  assign rd_data_a = data_q[rd_addr_a];
  assign rd_data_b = data_q[rd_addr_b];
  assign rd_flags  = flags_q[rd_addr_f];

endmodule

`default_nettype wire

// ==== design/writeback_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_arbiter
  import exec_pkg::*;
(
  input  wire      clk,
  input  wire      rst,
  input  wire wb_t alu_result,
  input  wire wb_t mul_result,
  output wb_t      wr,
  output logic     alu_hold_full
);

  wb_t  hold_q;
  logic full_q;
  logic load;

  // ALU result waits if the port is taken by mul or by an older held result
  assign load = alu_result.valid && (mul_result.valid || full_q);

  always_comb begin
    if (mul_result.valid)
      wr = mul_result;
    else if (full_q)
      wr = hold_q;
    else
      wr = alu_result;
  end

  // also high in the cycle the hold is about to fill
  assign alu_hold_full = full_q || (mul_result.valid && alu_result.valid);

  always_ff @(posedge clk) begin
    if (load)
      hold_q <= alu_result;
    if (rst)
      full_q <= 1'b0;
    else
      full_q <= load || (full_q && mul_result.valid);
  end

  // issue side keeps a third result from arriving while hold and port are busy
  a_hold_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    (full_q && mul_result.valid) |-> !alu_result.valid);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the exec_cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f \
  --top-module exec_cluster_tb -Mdir obj_dir -o exec_cluster_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/exec_cluster_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
exit 1

// ==== sim.f ====
design/isa_pkg.sv
design/exec_pkg.sv
design/issue_ctrl.sv
design/reg_file.sv
design/alu_unit.sv
design/mul_unit.sv
design/writeback_arbiter.sv
design/exec_cluster.sv
testbench/tb_clock.sv
testbench/exec_cluster_tb.sv

// ==== testbench/exec_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb
  import isa_pkg::*;
  import exec_pkg::*;
;

  localparam int wait_limit = 200;

  logic  clk;
  logic  rst;
  logic  issue_valid;
  insn_u issue_insn;
  logic  issue_ready;
  wb_t   wb;

  word_t       model_reg [num_regs];
  flags_t      model_flg [num_regs];
  logic        exp_v [num_regs];
  word_t       exp_d [num_regs];
  flags_t      exp_f [num_regs];
  int          wb_log [$];
  int          errors;
  int          checks;
  logic [31:0] rng_state;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  exec_cluster dut (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_insn  (issue_insn),
    .issue_ready (issue_ready),
    .wb          (wb)
  );

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic insn_u make_reg(input int op, input int cond, input int rd,
                                     input int ra, input int rb, input int rf);
    insn_u w;
    w = '0;
    w[38:34] = op[4:0];
    w[33:30] = cond[3:0];
    w[29:26] = rd[3:0];
    w[25:22] = ra[3:0];
    w[21:18] = rb[3:0];
    w[17:14] = rf[3:0];
    return w;
  endfunction

  function automatic insn_u make_imm(input int op, input int rd, input int ra,
                                     input logic [25:0] imm);
    insn_u w;
    w = '0;
    w[39]    = 1'b1;
    w[38:34] = op[4:0];
    w[33:30] = rd[3:0];
    w[29:26] = ra[3:0];
    w[25:0]  = imm;
    return w;
  endfunction

  function automatic logic cond_pass(input int cond, input flags_t f);
    case (cond)
      0:  return f.z;
      1:  return !f.z;
      2:  return f.c;
      3:  return !f.c;
      4:  return f.n;
      5:  return !f.n;
      6:  return f.v;
      7:  return !f.v;
      8:  return f.c && !f.z;
      9:  return !f.c || f.z;
      10: return f.n == f.v;
      11: return f.n != f.v;
      12: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // reference result from the instruction rules
  task automatic compute(input int op, input word_t a, input word_t b,
                         output word_t d, output flags_t f);
    logic [64:0]         s;
    logic [127:0]        pu;
    logic signed [127:0] ps;
    f = '0;
    case (op)
      1: begin
        s   = {1'b0, a} - {1'b0, b};
        d   = s[63:0];
        f.c = a >= b;
        f.v = (a[63] != b[63]) && (d[63] != a[63]);
      end
      2: d = a & b;
      3: d = a ^ b;
      4: d = a | b;
      5: d = a << b[5:0];
      6: d = a >> b[5:0];
      7: d = $signed(a) >>> b[5:0];
      8, 9: begin
        pu = {64'b0, a} * {64'b0, b};
        d  = (op == 8) ? pu[63:0] : pu[127:64];
      end
      10: begin
        ps = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
        d  = ps[127:64];
      end
      default: begin
        s   = {1'b0, a} + {1'b0, b};
        d   = s[63:0];
        f.c = s[64];
        f.v = (a[63] == b[63]) && (d[63] != a[63]);
      end
    endcase
    f.n = d[63];
    f.z = d == 64'd0;
  endtask

  // called at the drive point, returns at the drive point after acceptance
  task automatic issue(input insn_u insn);
    int     t;
    int     op;
    int     cond;
    int     rd;
    word_t  a;
    word_t  b;
    flags_t tf;
    word_t  d;
    flags_t f;
    issue_valid = 1'b1;
    issue_insn  = insn;
    t = 0;
    @(negedge clk);
    while (!issue_ready && t < wait_limit) begin
      t++;
      @(negedge clk);
    end
    if (!issue_ready) begin
      errors++;
      $display("issue_ready never came high for instruction %h at %0t", insn, $time);
      @(posedge clk);
      #1 issue_valid = 1'b0;
    end else begin
      op = insn[38:34];
      if (op > 10)
        op = 0;
      if (insn[39]) begin
        rd   = insn[33:30];
        a    = model_reg[insn[29:26]];
        b    = {{38{insn[25]}}, insn[25:0]};
        cond = 12;
        tf   = '0;
      end else begin
        cond = insn[33:30];
        rd   = insn[29:26];
        a    = model_reg[insn[25:22]];
        b    = model_reg[insn[21:18]];
        tf   = model_flg[insn[17:14]];
      end
      if (cond_pass(cond, tf)) begin
        compute(op, a, b, d, f);
        exp_v[rd] = 1'b1;
        exp_d[rd] = d;
        exp_f[rd] = f;
      end
      @(posedge clk);
      #1 issue_valid = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int   t;
    logic busy;
    t = 0;
    busy = 1'b1;
    while (busy && t < wait_limit) begin
      @(posedge clk);
      t++;
      busy = 1'b0;
      for (int r = 0; r < num_regs; r++)
        busy = busy | exp_v[r];
    end
    for (int r = 0; r < num_regs; r++) begin
      if (exp_v[r]) begin
        errors++;
        $display("result for register %0d never arrived", r);
        exp_v[r] = 1'b0;
      end
    end
    // back to the drive point
    #1;
  endtask

  // builds a random 64-bit value from 26-bit pieces, r0 holds zero
  task automatic load_random(input int rd);
    issue(make_imm(0, rd, 0, xorshift()));
    issue(make_imm(5, rd, rd, 26'd22));
    issue(make_imm(3, rd, rd, xorshift()));
    issue(make_imm(5, rd, rd, 26'd22));
    issue(make_imm(3, rd, rd, xorshift()));
  endtask

  // r1 = 1, r2 = -1, r3 = max positive, r4 = min negative
  task automatic load_constants();
    issue(make_imm(0, 1, 0, 26'd1));
    issue(make_imm(0, 2, 0, '1));
    issue(make_imm(6, 3, 2, 26'd1));
    issue(make_imm(5, 4, 1, 26'd63));
  endtask

  function automatic int find_wb(input int rd);
    foreach (wb_log[i])
      if (wb_log[i] == rd)
        return i;
    return -1;
  endfunction

  always @(negedge clk) begin
    if (!rst && wb.valid) begin
      wb_log.push_back(wb.rd);
      if (!exp_v[wb.rd]) begin
        errors++;
        $display("unexpected writeback to register %0d at %0t", wb.rd, $time);
      end else begin
        check_word("wb.data", wb.data, exp_d[wb.rd]);
        check_flags("wb.flags", wb.flags, exp_f[wb.rd]);
        model_reg[wb.rd] = exp_d[wb.rd];
        model_flg[wb.rd] = exp_f[wb.rd];
        exp_v[wb.rd] = 1'b0;
      end
    end
  end

  task automatic test_reset();
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      checks++;
      if (wb.valid !== 1'b0) begin
        errors++;
        $display("Fail at %0t: wb.valid got %b expected 0", $time, wb.valid);
      end
      if (issue_ready !== 1'b1) begin
        errors++;
        $display("Fail at %0t: issue_ready got %b expected 1", $time, issue_ready);
      end
    end
    @(posedge clk);
    #1;
    // zero flags make conditions z, c, n and v false, so nothing is written
    for (int r = 0; r < num_regs; r++)
      for (int c = 0; c < 8; c += 2)
        issue(make_reg(0, c, r, r, r, r));
    for (int r = 0; r < num_regs; r++)
      issue(make_imm(0, r, r, 26'd0));
    wait_idle();
  endtask

  task automatic test_alu_ops();
    load_constants();
    for (int op = 0; op < 8; op++) begin
      for (int k = 0; k < 3; k++) begin
        load_random(5);
        load_random(6);
        issue(make_reg(op, 12, 7, 5, 6, 0));
        issue(make_imm(op, 8, 5, xorshift()));
      end
      issue(make_reg(op, 12, 9, 2, 1, 0));
      issue(make_reg(op, 12, 10, 3, 1, 0));
      issue(make_reg(op, 12, 11, 4, 1, 0));
      issue(make_reg(op, 12, 12, 4, 4, 0));
      issue(make_reg(op, 12, 13, 3, 2, 0));
    end
    wait_idle();
  endtask

  task automatic test_conditions();
    // flag patterns in r5 to r11
    issue(make_reg(0, 12, 5, 0, 0, 0));
    issue(make_reg(0, 12, 6, 2, 1, 0));
    issue(make_reg(0, 12, 7, 1, 1, 0));
    issue(make_reg(0, 12, 8, 2, 2, 0));
    issue(make_reg(0, 12, 9, 3, 1, 0));
    issue(make_reg(0, 12, 10, 4, 4, 0));
    issue(make_reg(1, 12, 11, 1, 2, 0));
    for (int p = 5; p <= 11; p++) begin
      for (int c = 0; c < 16; c++) begin
        issue(make_reg(0, c, 12, 12, 1, p));
        issue(make_imm(0, 13, 12, 26'd0));
      end
    end
    wait_idle();
  endtask

  task automatic test_multiply();
    for (int op = 8; op <= 10; op++) begin
      for (int k = 0; k < 3; k++) begin
        load_random(5);
        load_random(6);
        issue(make_reg(op, 12, 7, 5, 6, 0));
      end
      issue(make_reg(op, 12, 8, 2, 4, 0));
      issue(make_reg(op, 12, 9, 4, 4, 0));
      issue(make_reg(op, 12, 10, 3, 2, 0));
      issue(make_reg(op, 12, 11, 2, 2, 0));
    end
    wait_idle();
  endtask

  task automatic test_collision();
    load_random(5);
    load_random(6);
    wait_idle();
    for (int k = 0; k < 3; k++) begin
      wb_log.delete();
      issue(make_reg(8 + k, 12, 7, 5, 6, 0));
      issue(make_reg(0, 12, 8, 5, 6, 0));
      issue(make_reg(3, 12, 9, 5, 6, 0));
      issue(make_reg(1, 12, 10, 6, 5, 0));
      wait_idle();
      checks++;
      if (wb_log.size() != 4 || find_wb(7) < 0 || find_wb(7) > find_wb(9)) begin
        errors++;
        $display("collision round %0d: multiply result missing or after ALU result", k);
      end
    end
  endtask

  task automatic test_chain();
    load_random(5);
    load_random(6);
    issue(make_reg(0, 12, 7, 5, 6, 0));
    issue(make_reg(8, 12, 7, 7, 5, 0));
    issue(make_reg(3, 12, 7, 7, 6, 0));
    issue(make_reg(10, 12, 7, 7, 6, 0));
    issue(make_reg(1, 12, 7, 7, 5, 0));
    issue(make_reg(9, 12, 7, 7, 7, 0));
    issue(make_imm(7, 7, 7, 26'd5));
    issue(make_imm(0, 8, 7, 26'd0));
    wait_idle();
  endtask

  initial begin
    int t;
    issue_valid = 1'b0;
    issue_insn  = '0;
    errors      = 0;
    checks      = 0;
    rng_state   = 32'hca5b;
    for (int r = 0; r < num_regs; r++) begin
      model_reg[r] = '0;
      model_flg[r] = '0;
      exp_v[r]     = 1'b0;
      exp_d[r]     = '0;
      exp_f[r]     = '0;
    end
    t = 0;
    while (rst !== 1'b0 && t < wait_limit) begin
      t++;
      @(negedge clk);
    end
    if (rst !== 1'b0) begin
      errors++;
      $display("reset was never released");
    end
    test_reset();
    test_alu_ops();
    test_conditions();
    test_multiply();
    test_collision();
    test_chain();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire
